// ==== Makefile ====
# Verilator build and run for the QPSK modulator testbench

VERILATOR ?= verilator
TOP       ?= tb_qpsk_tx
BUILD_DIR ?= obj_dir
FILELIST  ?= build.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard include/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG) || { echo "Simulation failed"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
+incdir+include
verilog/tx_types_pkg.sv
verilog/tx_regs_pkg.sv
verilog/tx_csr.sv
verilog/prbs_gen.sv
verilog/symbol_timing.sv
verilog/polyph_filter.sv
verilog/qpsk_tx.sv
tb/tb_qpsk_tx.sv

// ==== include/tx_macros.svh ====
`ifndef TX_MACROS_SVH
`define TX_MACROS_SVH

// Samples per symbol
`define TX_OS 4

// Pulse span in symbols
`define TX_NBAUD 6

// Coefficient width, S(8,7)
`define TX_COEF_W 8

// Output sample width, S(8,7)
`define TX_OUT_W 8

// Wishbone bus sizes
`define TX_WB_AW 8
`define TX_WB_DW 16

`endif

// ==== tb/tb_qpsk_tx.sv ====
`timescale 1ns/1ps

module tb_qpsk_tx;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 10;
  localparam int RUN_CYCLES   = 400;
  localparam int SAT_CYCLES   = 300;
  localparam int RERUN_CYCLES = 200;
  // Register accesses in the five tests, each at most four cycles long
  localparam int N_XFERS      = 5 + 7 + 27 + 28 + 5;
  localparam int XFER_CYCLES  = 4;
  localparam int TEST_CYCLES  = RESET_CYCLES + RUN_CYCLES + SAT_CYCLES + RERUN_CYCLES +
                                N_XFERS * XFER_CYCLES;
  localparam int MARGIN       = 300;
  localparam int ACK_LIMIT    = 20;

  logic        clk;
  logic        i_reset;
  logic        i_wb_cyc;
  logic        i_wb_stb;
  logic        i_wb_we;
  logic [7:0]  i_wb_adr;
  logic [15:0] i_wb_dat;
  logic [15:0] o_wb_dat;
  logic        o_wb_ack;
  logic [7:0]  o_i_sample;
  logic [7:0]  o_q_sample;
  logic        o_sample_valid;

  integer seed;
  int     errors;
  int     checked;
  int     sat_hits;
  logic   checking;

  // Reference model state
  int          m_coef [24];
  logic [8:0]  m_seed_i;
  logic [8:0]  m_seed_q;
  logic [8:0]  m_lfsr_i;
  logic [8:0]  m_lfsr_q;
  logic [5:0]  m_sh_i;
  logic [5:0]  m_sh_q;
  logic [1:0]  m_phase;
  logic        m_en;
  logic        m_ack;
  logic [15:0] m_symcnt;
  logic [15:0] snap_symcnt;
  logic [7:0]  exp_i;
  logic [7:0]  exp_q;
  logic        exp_v;
  logic        exp_clip;

  qpsk_tx DUT (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_wb_cyc       (i_wb_cyc),
    .i_wb_stb       (i_wb_stb),
    .i_wb_we        (i_wb_we),
    .i_wb_adr       (i_wb_adr),
    .i_wb_dat       (i_wb_dat),
    .o_wb_dat       (o_wb_dat),
    .o_wb_ack       (o_wb_ack),
    .o_i_sample     (o_i_sample),
    .o_q_sample     (o_q_sample),
    .o_sample_valid (o_sample_valid)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  // Signed sum of the six taps of one rail
  function automatic int tap_sum(input logic [5:0] sh, input logic [1:0] ph);
    int s;
    int c;
    s = 0;
    for (int t = 0; t < 6; t++) begin
      c = m_coef[t*4 + int'(ph)];
      s = sh[t] ? s - c : s + c;
    end
    return s;
  endfunction

  // Largest code for a positive overflow, smallest for a negative one
  function automatic logic [7:0] clip8(input int s);
    if (s > 127) begin
      return 8'h7F;
    end else if (s < -128) begin
      return 8'h80;
    end
    return s[7:0];
  endfunction

  function automatic logic [8:0] nonzero(input logic [8:0] v);
    return (v == 9'd0) ? 9'd1 : v;
  endfunction

  function automatic logic [8:0] lfsr_step(input logic [8:0] v);
    return {v[7:0], v[8] ^ v[4]};
  endfunction

  // Model steps on each edge from the values held before it
  always @(posedge clk) begin
    logic shift;
    logic wr;
    int   sum_i;
    int   sum_q;
    if (i_reset) begin
      m_en     = 1'b0;
      m_ack    = 1'b0;
      m_seed_i = '0;
      m_seed_q = '0;
      m_lfsr_i = 9'd1;
      m_lfsr_q = 9'd1;
      m_sh_i   = '0;
      m_sh_q   = '0;
      m_phase  = '0;
      m_symcnt = '0;
      exp_v   <= 1'b0;
      for (int k = 0; k < 24; k++) begin
        m_coef[k] = 0;
      end
    end else begin
      shift = m_en && (m_phase == 2'd3);
      wr    = m_ack && i_wb_cyc && i_wb_stb && i_wb_we;
      sum_i = tap_sum(m_sh_i, m_phase);
      sum_q = tap_sum(m_sh_q, m_phase);
      exp_i <= clip8(sum_i);
      exp_q <= clip8(sum_q);
      exp_v <= m_en;
      exp_clip <= (sum_i > 127) || (sum_i < -128) ||
                  (sum_q > 127) || (sum_q < -128);
      if (shift) begin
        m_sh_i = {m_sh_i[4:0], m_lfsr_i[8]};
        m_sh_q = {m_sh_q[4:0], m_lfsr_q[8]};
      end
      if (!m_en) begin
        m_lfsr_i = nonzero(m_seed_i);
        m_lfsr_q = nonzero(m_seed_q);
      end else if (shift) begin
        m_lfsr_i = lfsr_step(m_lfsr_i);
        m_lfsr_q = lfsr_step(m_lfsr_q);
      end
      if (wr && i_wb_adr == 8'h00) begin
        m_symcnt = '0;
      end else if (shift) begin
        m_symcnt = m_symcnt + 16'd1;
      end
      m_phase = m_en ? m_phase + 2'd1 : 2'd0;
      if (wr) begin
        if (i_wb_adr == 8'h00) m_en = i_wb_dat[0];
        if (i_wb_adr == 8'h04) m_seed_i = i_wb_dat[8:0];
        if (i_wb_adr == 8'h08) m_seed_q = i_wb_dat[8:0];
        if (i_wb_adr >= 8'h40 && i_wb_adr < 8'h58) begin
          m_coef[i_wb_adr - 8'h40] = int'($signed(i_wb_dat[7:0]));
        end
      end
      m_ack = !m_ack && i_wb_cyc && i_wb_stb;
    end
  end

  // Output checks away from the active edge
  always @(negedge clk) begin
    if (checking) begin
      assert (o_sample_valid == exp_v) else begin
        $display("FAIL o_sample_valid exp %h got %h", exp_v, o_sample_valid);
        errors++;
      end
      assert (o_wb_ack == m_ack) else begin
        $display("FAIL o_wb_ack exp %h got %h", m_ack, o_wb_ack);
        errors++;
      end
      assert (DUT.u_timing.o_phase == m_phase) else begin
        $display("FAIL o_phase exp %h got %h", m_phase, DUT.u_timing.o_phase);
        errors++;
      end
      if (exp_v) begin
        checked++;
        if (exp_clip) begin
          sat_hits++;
        end
        assert (o_i_sample == exp_i) else begin
          $display("FAIL o_i_sample exp %h got %h", exp_i, o_i_sample);
          errors++;
        end
        assert (o_q_sample == exp_q) else begin
          $display("FAIL o_q_sample exp %h got %h", exp_q, o_q_sample);
          errors++;
        end
      end
    end
  end

  // Hold the request until ack, then make sure ack drops after one cycle
  task automatic bus_cycle(input logic we, input logic [7:0] adr, input logic [15:0] dat,
                           output logic [15:0] rd);
    int n;
    n = 0;
    @(posedge clk);
    i_wb_cyc <= 1'b1;
    i_wb_stb <= 1'b1;
    i_wb_we  <= we;
    i_wb_adr <= adr;
    i_wb_dat <= dat;
    @(negedge clk);
    while (!o_wb_ack && n < ACK_LIMIT) begin
      @(negedge clk);
      n++;
    end
    assert (o_wb_ack) else begin
      $display("Bus cycle to address %h got no ack", adr);
      errors++;
    end
    rd = o_wb_dat;
    snap_symcnt = m_symcnt;
    @(posedge clk);
    i_wb_cyc <= 1'b0;
    i_wb_stb <= 1'b0;
    i_wb_we  <= 1'b0;
    @(negedge clk);
    assert (!o_wb_ack) else begin
      $display("Ack stayed high for more than one cycle");
      errors++;
    end
  endtask

  task automatic write_reg(input logic [7:0] adr, input logic [15:0] dat);
    logic [15:0] unused;
    bus_cycle(1'b1, adr, dat, unused);
  endtask

  task automatic read_check(input logic [7:0] adr, input logic [15:0] exp);
    logic [15:0] rd;
    bus_cycle(1'b0, adr, 16'h0000, rd);
    assert (rd == exp) else begin
      $display("FAIL o_wb_dat at %h exp %h got %h", adr, exp, rd);
      errors++;
    end
  endtask

  task automatic load_seeds();
    write_reg(8'h04, 16'(({$random(seed)} % 511) + 1));
    write_reg(8'h08, 16'(({$random(seed)} % 511) + 1));
  endtask

  initial begin
    #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    logic [15:0] v;
    logic [15:0] rd;
    seed     = 94308;
    errors   = 0;
    checked  = 0;
    sat_hits = 0;
    checking = 1'b0;
    clk      = 1'b0;
    i_reset  <= 1'b1;
    i_wb_cyc <= 1'b0;
    i_wb_stb <= 1'b0;
    i_wb_we  <= 1'b0;
    i_wb_adr <= '0;
    i_wb_dat <= '0;
    repeat (RESET_CYCLES) @(posedge clk);
    i_reset <= 1'b0;
    @(negedge clk);
    checking = 1'b1;

    // Reset state
    assert (!o_sample_valid && !o_wb_ack) else begin
      $display("Valid or ack not low after reset");
      errors++;
    end
    read_check(8'h00, 16'h0000);
    read_check(8'h04, 16'h0000);
    read_check(8'h08, 16'h0000);
    read_check(8'h0C, 16'h0000);
    read_check(8'h45, 16'h0000);

    // Register readback
    v = 16'($random(seed));
    write_reg(8'h04, v);
    read_check(8'h04, v & 16'h01FF);
    v = 16'($random(seed));
    write_reg(8'h08, v);
    read_check(8'h08, v & 16'h01FF);
    v = 16'($random(seed));
    write_reg(8'h00, v);
    read_check(8'h00, v & 16'h0001);
    write_reg(8'h00, 16'h0000);

    // Random coefficients
    for (int k = 0; k < 24; k++) begin
      write_reg(8'(8'h40 + k), 16'($random(seed)) & 16'h00FF);
    end
    load_seeds();
    write_reg(8'h00, 16'h0001);
    repeat (RUN_CYCLES) @(posedge clk);

    // Full scale coefficients force saturation
    write_reg(8'h00, 16'h0000);
    for (int k = 0; k < 24; k++) begin
      write_reg(8'(8'h40 + k), 16'h007F);
    end
    load_seeds();
    sat_hits = 0;
    write_reg(8'h00, 16'h0001);
    repeat (SAT_CYCLES) @(posedge clk);
    assert (sat_hits > 0) else begin
      $display("No clipped sample was compared with full scale coefficients");
      errors++;
    end

    // Symbol count, stop and restart
    bus_cycle(1'b0, 8'h0C, 16'h0000, rd);
    assert (rd == snap_symcnt) else begin
      $display("FAIL SYMCNT exp %h got %h", snap_symcnt, rd);
      errors++;
    end
    write_reg(8'h00, 16'h0000);
    @(negedge clk);
    assert (!o_sample_valid) else begin
      $display("Valid still high one cycle after enable was cleared");
      errors++;
    end
    load_seeds();
    write_reg(8'h00, 16'h0001);
    repeat (RERUN_CYCLES) @(posedge clk);

    assert (checked > 0) else begin
      $display("No valid samples were observed");
      errors++;
    end
    @(negedge clk);
    $display("Errors: %0d, samples checked: %0d", errors, checked);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== verilog/polyph_filter.sv ====
`timescale 1ns/1ps
`include "tx_macros.svh"

module polyph_filter #(
  parameter int NBAUD = `TX_NBAUD,
  parameter int OS    = `TX_OS
) (
  input  logic                     clk,
  input  logic                     i_reset,
  input  logic                     i_enable,
  input  logic                     i_bit,
  input  logic                     i_shift,
  input  tx_types_pkg::phase_t     i_phase,
  input  logic                     i_coef_we,
  input  tx_types_pkg::coef_addr_t i_coef_addr,
  input  tx_types_pkg::coef_t      i_coef_data,
  output tx_types_pkg::sample_t    o_sample,
  output logic                     o_valid
);

  import tx_types_pkg::*;

  localparam int NCOEF = NBAUD * OS;
  localparam int ACC_W = $bits(acc_t);
  localparam int OUT_W = $bits(sample_t);
  // Output sign bit plus the growth bits above it
  localparam int NB_CHK = ACC_W - OUT_W + 1;

  coef_t            coef_mem [NCOEF];
  logic [NBAUD-1:0] shifter;
  acc_t             part [NBAUD];
  acc_t             sum;
  logic             in_range;
  sample_t          sat;

  // Coefficient bank, written from the bus
  always_ff @(posedge clk) begin
    if (i_reset) begin
      for (int k = 0; k < NCOEF; k++) begin
        coef_mem[k] <= '0;
      end
    end else if (i_coef_we && (i_coef_addr < NCOEF)) begin
      coef_mem[i_coef_addr] <= i_coef_data;
    end
  end

  // Symbol history, bit 0 is the newest symbol
  always_ff @(posedge clk) begin
    if (i_reset) begin
      shifter <= '0;
    end else if (i_shift) begin
      shifter <= {shifter[NBAUD-2:0], i_bit};
    end
  end

  // Bit 1 maps to -1, so the tap just flips the coefficient sign
  for (genvar t = 0; t < NBAUD; t++) begin : g_tap
    coef_t c;

    assign c = coef_mem[t*OS + i_phase];
    // Widen before negating so -128 stays representable
    assign part[t] = shifter[t] ? -acc_t'(c) : acc_t'(c);
  end

  always_comb begin
    sum = '0;
    for (int t = 0; t < NBAUD; t++) begin
      sum = sum + part[t];
    end
  end

  // Same fraction bits in and out, only the integer part is clipped
  assign in_range = (&sum[ACC_W-1 -: NB_CHK]) || !(|sum[ACC_W-1 -: NB_CHK]);

  always_comb begin
    if (in_range) begin
      sat = sample_t'(sum[OUT_W-1:0]);
    end else if (sum[ACC_W-1]) begin
      sat = {1'b1, {(OUT_W-1){1'b0}}};
    end else begin
      sat = {1'b0, {(OUT_W-1){1'b1}}};
    end
  end

  always_ff @(posedge clk) begin
    o_sample <= sat;
  end

  // Valid trails enable by the one register stage
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_enable;
    end
  end

endmodule

// ==== verilog/prbs_gen.sv ====
`timescale 1ns/1ps

module prbs_gen (
  input  logic       clk,
  input  logic       i_reset,
  input  logic       i_enable,
  input  logic [8:0] i_seed,
  input  logic       i_advance,
  output logic       o_bit
);

  logic [8:0] lfsr;
  logic [8:0] seed_ok;
  logic       fb;

  // All-zero state would lock the register
  assign seed_ok = (i_seed == '0) ? 9'd1 : i_seed;

  // x^9 + x^5 + 1
  assign fb = lfsr[8] ^ lfsr[4];

  always_ff @(posedge clk) begin
    if (i_reset) begin
      lfsr <= seed_ok;
    end else if (!i_enable) begin
      // Idle, keep tracking the seed register
      lfsr <= seed_ok;
    end else if (i_advance) begin
      lfsr <= {lfsr[7:0], fb};
    end
  end

  assign o_bit = lfsr[8];

endmodule

// ==== verilog/qpsk_tx.sv ====
`timescale 1ns/1ps

module qpsk_tx (
  input  logic                  clk,
  input  logic                  i_reset,
  input  logic                  i_wb_cyc,
  input  logic                  i_wb_stb,
  input  logic                  i_wb_we,
  input  tx_regs_pkg::wb_addr_t i_wb_adr,
  input  tx_regs_pkg::wb_data_t i_wb_dat,
  output tx_regs_pkg::wb_data_t o_wb_dat,
  output logic                  o_wb_ack,
  output tx_types_pkg::sample_t o_i_sample,
  output tx_types_pkg::sample_t o_q_sample,
  output logic                  o_sample_valid
);

  import tx_types_pkg::*;

  logic       enable;
  logic [8:0] seed_i;
  logic [8:0] seed_q;
  logic       coef_we;
  coef_addr_t coef_addr;
  coef_t      coef_data;
  phase_t     phase;
  logic       shift;
  logic       bit_i;
  logic       bit_q;

  tx_csr u_csr (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_wb_cyc    (i_wb_cyc),
    .i_wb_stb    (i_wb_stb),
    .i_wb_we     (i_wb_we),
    .i_wb_adr    (i_wb_adr),
    .i_wb_dat    (i_wb_dat),
    .o_wb_dat    (o_wb_dat),
    .o_wb_ack    (o_wb_ack),
    .i_shift     (shift),
    .o_enable    (enable),
    .o_seed_i    (seed_i),
    .o_seed_q    (seed_q),
    .o_coef_we   (coef_we),
    .o_coef_addr (coef_addr),
    .o_coef_data (coef_data)
  );

  symbol_timing u_timing (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_enable (enable),
    .o_phase  (phase),
    .o_shift  (shift)
  );

  prbs_gen u_prbs_i (
    .clk       (clk),
    .i_reset   (i_reset),
    .i_enable  (enable),
    .i_seed    (seed_i),
    .i_advance (shift),
    .o_bit     (bit_i)
  );

  prbs_gen u_prbs_q (
    .clk       (clk),
    .i_reset   (i_reset),
    .i_enable  (enable),
    .i_seed    (seed_q),
    .i_advance (shift),
    .o_bit     (bit_q)
  );

  // Both rails share one coefficient image
  polyph_filter u_filt_i (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_enable    (enable),
    .i_bit       (bit_i),
    .i_shift     (shift),
    .i_phase     (phase),
    .i_coef_we   (coef_we),
    .i_coef_addr (coef_addr),
    .i_coef_data (coef_data),
    .o_sample    (o_i_sample),
    .o_valid     (o_sample_valid)
  );

  // Q valid is identical to I valid
  polyph_filter u_filt_q (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_enable    (enable),
    .i_bit       (bit_q),
    .i_shift     (shift),
    .i_phase     (phase),
    .i_coef_we   (coef_we),
    .i_coef_addr (coef_addr),
    .i_coef_data (coef_data),
    .o_sample    (o_q_sample),
    .o_valid     ()
  );

endmodule

// ==== verilog/symbol_timing.sv ====
`timescale 1ns/1ps
`include "tx_macros.svh"

module symbol_timing (
  input  logic                 clk,
  input  logic                 i_reset,
  input  logic                 i_enable,
  output tx_types_pkg::phase_t o_phase,
  output logic                 o_shift
);

  import tx_types_pkg::*;

  localparam phase_t LAST = phase_t'(`TX_OS - 1);

  phase_t phase;

  // Modulo-OS counter, parked at 0 while disabled
  always_ff @(posedge clk) begin
    if (i_reset) begin
      phase <= '0;
    end else if (!i_enable) begin
      phase <= '0;
    end else if (phase == LAST) begin
      phase <= '0;
    end else begin
      phase <= phase + 1'b1;
    end
  end

  assign o_phase = phase;

  // Last sample of the symbol, new bits enter on the next edge
  assign o_shift = i_enable && (phase == LAST);

endmodule

// ==== verilog/tx_csr.sv ====
`timescale 1ns/1ps
`include "tx_macros.svh"

module tx_csr (
  input  logic                     clk,
  input  logic                     i_reset,
  input  logic                     i_wb_cyc,
  input  logic                     i_wb_stb,
  input  logic                     i_wb_we,
  input  tx_regs_pkg::wb_addr_t    i_wb_adr,
  input  tx_regs_pkg::wb_data_t    i_wb_dat,
  output tx_regs_pkg::wb_data_t    o_wb_dat,
  output logic                     o_wb_ack,
  input  logic                     i_shift,
  output logic                     o_enable,
  output logic [8:0]               o_seed_i,
  output logic [8:0]               o_seed_q,
  output logic                     o_coef_we,
  output tx_types_pkg::coef_addr_t o_coef_addr,
  output tx_types_pkg::coef_t      o_coef_data
);

  import tx_regs_pkg::*;
  import tx_types_pkg::*;

  localparam int NCOEF = `TX_NBAUD * `TX_OS;

  wb_state_e state;
  logic      wr_cycle;
  logic      is_coef;
  wb_addr_t  coef_off;
  wb_data_t  symcnt;

  // One ack cycle per bus request, then back to idle
  always_ff @(posedge clk) begin
    if (i_reset) begin
      state <= WB_IDLE;
    end else begin
      case (state)
        WB_IDLE: begin
          if (i_wb_cyc && i_wb_stb) begin
            state <= WB_ACK;
          end
        end
        default: begin
          state <= WB_IDLE;
        end
      endcase
    end
  end

  assign o_wb_ack = (state == WB_ACK);

  // Writes land on the edge that closes the ack cycle
  assign wr_cycle = o_wb_ack && i_wb_cyc && i_wb_stb && i_wb_we;

  // Coefficient window decode
  assign coef_off = i_wb_adr - COEF_BASE;
  assign is_coef  = (i_wb_adr >= COEF_BASE) && (coef_off < NCOEF);

  assign o_coef_we   = wr_cycle && is_coef;
  assign o_coef_addr = coef_addr_t'(coef_off);
  assign o_coef_data = coef_t'(i_wb_dat[`TX_COEF_W-1:0]);

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_enable <= 1'b0;
      o_seed_i <= '0;
      o_seed_q <= '0;
    end else if (wr_cycle) begin
      case (i_wb_adr)
        REG_CTRL:   o_enable <= i_wb_dat[0];
        REG_SEED_I: o_seed_i <= i_wb_dat[8:0];
        REG_SEED_Q: o_seed_q <= i_wb_dat[8:0];
        default:    ;
      endcase
    end
  end

  // Symbol counter, restarted by any CTRL write
  always_ff @(posedge clk) begin
    if (i_reset) begin
      symcnt <= '0;
    end else if (wr_cycle && (i_wb_adr == REG_CTRL)) begin
      symcnt <= '0;
    end else if (i_shift) begin
      symcnt <= symcnt + 1'b1;
    end
  end

  // Read mux, coefficients are write-only
  always_comb begin
    o_wb_dat = '0;
    case (i_wb_adr)
      REG_CTRL:   o_wb_dat[0]   = o_enable;
      REG_SEED_I: o_wb_dat[8:0] = o_seed_i;
      REG_SEED_Q: o_wb_dat[8:0] = o_seed_q;
      REG_SYMCNT: o_wb_dat      = symcnt;
      default:    o_wb_dat      = '0;
    endcase
  end

endmodule

// ==== verilog/tx_regs_pkg.sv ====
`include "tx_macros.svh"

package tx_regs_pkg;

  // Wishbone address and data
  typedef logic [`TX_WB_AW-1:0] wb_addr_t;
  typedef logic [`TX_WB_DW-1:0] wb_data_t;

  // Register map
  localparam wb_addr_t REG_CTRL   = 8'h00;
  localparam wb_addr_t REG_SEED_I = 8'h04;
  localparam wb_addr_t REG_SEED_Q = 8'h08;
  localparam wb_addr_t REG_SYMCNT = 8'h0C;
  localparam wb_addr_t COEF_BASE  = 8'h40;

  // Bus handshake states
  typedef enum logic {
    WB_IDLE,
    WB_ACK
  } wb_state_e;

endpackage

// ==== verilog/tx_types_pkg.sv ====
`include "tx_macros.svh"

package tx_types_pkg;

  // Filter coefficient, S(8,7)
  typedef logic signed [`TX_COEF_W-1:0] coef_t;

  // Shaped output sample, S(8,7)
  typedef logic signed [`TX_OUT_W-1:0] sample_t;

  // Sum of NBAUD partial products, needs log2 growth bits
  typedef logic signed [`TX_COEF_W+$clog2(`TX_NBAUD)-1:0] acc_t;

  // Sample phase within one symbol
  typedef logic [$clog2(`TX_OS)-1:0] phase_t;

  // Coefficient index, tap * OS + phase
  typedef logic [$clog2(`TX_NBAUD*`TX_OS)-1:0] coef_addr_t;

endpackage
